// ==== trs_io_top.f ====
+incdir+source
source/trs_bus_pkg.sv
source/esp_link_pkg.sv
source/spi_byte_receiver.sv
source/command_parser.sv
source/command_executor.sv
source/bus_port_decoder.sv
source/trs_io_top.sv
testbench/tb_clock.sv
testbench/trs_io_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the trs_io testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f trs_io_top.f \
  --top-module trs_io_tb -o trs_io_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/trs_io_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q -F '** PASS **'; then
  exit 0
fi
exit 1

// ==== testbench/trs_io_tb.sv ====
`timescale 1ns/1ns

module trs_io_tb;

  localparam logic [7:0] cookie_value  = 8'hAF;
  localparam logic [7:0] version_value = 8'h03;   // major 0, minor 3
  localparam int         req_cycles    = 50;

  logic clk, rst_n, sck, mosi, cs, miso;
  logic in_n, out_n, ioreq_n, d_oe, esp_req, esp_done, wait_out, int_out, extiosel;
  logic led_red, led_green, led_blue;
  logic [7:0] a, d_in, d_out, reply, rnd;
  logic [3:0] conf;
  logic [2:0] led;
  trs_bus_pkg::esp_request_t esp_s;

  tb_clock tb_clock_i (.clk(clk));

  trs_io_top trs_io_top_i (
    .clk(clk), .rst_n(rst_n), .sck(sck), .mosi(mosi), .cs(cs), .miso(miso),
    .a(a), .in_n(in_n), .out_n(out_n), .ioreq_n(ioreq_n), .d_in(d_in),
    .d_out(d_out), .d_oe(d_oe), .esp_s(esp_s), .esp_req(esp_req), .esp_done(esp_done),
    .wait_out(wait_out), .int_out(int_out), .extiosel(extiosel), .conf(conf),
    .led_red(led_red), .led_green(led_green), .led_blue(led_blue), .led(led)
  );

  task automatic fail_now(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("** FAIL **");
    $fatal(1, "check failed");
  endtask

  task automatic give_up(input string msg);
    $display("timed out: %s", msg);
    $display("** FAIL **");
    $fatal(1, "timeout");
  endtask

  task automatic tick(input int n);
    repeat (n) @(negedge clk);
  endtask

  // spi master, 5 cycle phases; nine miso samples so the stale first one drops out
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    rx = '0;
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      tick(5);
      rx = {rx[6:0], miso};   // rising sck edge
      sck = 1'b1;
      tick(5);
      sck = 1'b0;
    end
    tick(5);
    rx = {rx[6:0], miso};   // last bit, after the final fall
  endtask

  // command byte then one more byte; the reply comes back in the second one
  task automatic spi_frame(input logic [7:0] b0, input logic [7:0] b1,
                           output logic [7:0] rx);
    logic [7:0] unused;
    cs = 1'b0;
    spi_byte(b0, unused);
    spi_byte(b1, rx);
    cs = 1'b1;
    tick(6);
  endtask

  task automatic bus_start(input logic [7:0] addr, input logic rd);
    a       = addr;
    ioreq_n = 1'b0;
    in_n    = ~rd;
    out_n   = rd;
  endtask

  task automatic bus_end();
    ioreq_n = 1'b1;
    in_n    = 1'b1;
    out_n   = 1'b1;
    tick(6);   // let the synchronized access level drop
  endtask

  // full z80 access to an ESP port with the wait/esp_done handshake
  task automatic io_cycle(input logic [7:0] addr, input logic rd,
                          input trs_bus_pkg::esp_request_t code,
                          input logic check_data, input logic [7:0] data);
    int n;
    bus_start(addr, rd);
    tick(1);
    assert (esp_s == code) else fail_now($sformatf("esp_s %0d, expected %0d", esp_s, code));
    assert (d_oe == rd) else fail_now("d_oe does not match the access direction");
    assert (extiosel == rd) else fail_now("extiosel does not match the access direction");
    if (check_data)
      assert (d_out == data) else fail_now($sformatf("d_out %02h, expected %02h", d_out, data));
    n = 0;
    while (!wait_out) begin
      if (n == 20) give_up("wait never rose after the port access");
      tick(1);
      n++;
    end
    assert (esp_req) else fail_now("esp_req not high together with wait");
    assert (led[1:0] == 2'b11) else fail_now($sformatf("led %b during a request", led));
    n = 0;
    while (esp_req) begin
      if (n == 200) give_up("esp_req never fell");
      tick(1);
      n++;
    end
    assert (n == req_cycles) else fail_now($sformatf("esp_req high %0d cycles", n));
    tick(10);
    assert (wait_out) else fail_now("wait fell before esp_done");
    esp_done = 1'b1;
    n = 0;
    while (wait_out) begin
      if (n == 20) give_up("wait never fell after esp_done");
      tick(1);
      n++;
    end
    assert (n <= 4) else fail_now($sformatf("wait fell %0d cycles after esp_done", n));
    esp_done = 1'b0;
    bus_end();
  endtask

  initial begin
    void'($urandom(54364));
    rst_n    = 1'b0;
    sck      = 1'b0;
    mosi     = 1'b0;
    cs       = 1'b1;
    a        = 8'h00;
    in_n     = 1'b1;
    out_n    = 1'b1;
    ioreq_n  = 1'b1;
    d_in     = 8'h00;
    esp_done = 1'b0;
    conf     = 4'h0;
    tick(8);
    rst_n = 1'b1;
    tick(2);
    assert (!wait_out && !esp_req && !int_out && !d_oe && !led_red && !led_green && !led_blue
            && led == 3'b000)
      else fail_now("outputs not cleared by reset");

    // cookie and version
    spi_frame(esp_link_pkg::get_cookie, 8'hFF, reply);
    assert (reply == cookie_value) else fail_now($sformatf("cookie %02h", reply));
    spi_frame(esp_link_pkg::get_version, 8'hFF, reply);
    assert (reply == version_value) else fail_now($sformatf("version %02h", reply));

    // register writes
    rnd = 8'($urandom);
    repeat (2) begin
      spi_frame(esp_link_pkg::set_led, rnd, reply);
      assert ({led_blue, led_green, led_red} == rnd[2:0])
        else fail_now($sformatf("leds %b%b%b for %02h", led_blue, led_green, led_red, rnd));
      spi_frame(esp_link_pkg::set_esp_status, rnd, reply);
      assert (led[2] == rnd[0]) else fail_now("esp_ready does not follow esp status bit 0");
      rnd = ~rnd;   // every bit seen both ways
    end

    // bus reads and dip switches
    d_in = 8'($urandom);
    spi_frame(esp_link_pkg::dbus_read, 8'hFF, reply);
    assert (reply == d_in) else fail_now($sformatf("dbus_read %02h, d_in %02h", reply, d_in));
    a = 8'($urandom);
    spi_frame(esp_link_pkg::abus_read, 8'hFF, reply);
    assert (reply == a) else fail_now($sformatf("abus_read %02h, a %02h", reply, a));
    conf = 4'($urandom);
    spi_frame(esp_link_pkg::get_config, 8'hFF, reply);
    assert (reply == (8'h0F ^ {4'h0, conf})) else fail_now($sformatf("get_config %02h", reply));

    // request handshake
    io_cycle(8'h1F, 1'b1, trs_bus_pkg::trs_io_in, 1'b0, 8'h00);
    io_cycle(8'hC5, 1'b0, trs_bus_pkg::frehd_out, 1'b0, 8'h00);
    bus_start(8'h50, 1'b1);
    repeat (20) begin
      tick(1);
      assert (!wait_out && !esp_req && !extiosel && !led[1])
        else fail_now("undecoded port started a request");
    end
    assert (esp_s == trs_bus_pkg::no_request) else fail_now("esp_s set for undecoded port");
    bus_end();

    // data left by the ESP for the cpu
    rnd = 8'($urandom);
    spi_frame(esp_link_pkg::dbus_write, rnd, reply);
    io_cycle(8'h1F, 1'b1, trs_bus_pkg::trs_io_in, 1'b1, rnd);

    // interrupt set and acknowledge
    spi_frame(esp_link_pkg::data_ready, 8'hFF, reply);
    assert (int_out) else fail_now("int not raised by data_ready");
    io_cycle(8'h1F, 1'b0, trs_bus_pkg::trs_io_out, 1'b0, 8'h00);
    assert (!int_out) else fail_now("int not cleared by trs-io access");

    $display("** PASS **");
    $finish;
  end

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
  output logic clk
);

  // 10 ns period
  initial begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;

endmodule

// ==== source/trs_io_top.sv ====
`timescale 1ns/1ns

module trs_io_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      sck,
  input  logic                      mosi,
  input  logic                      cs,
  output logic                      miso,
  input  trs_bus_pkg::bus_addr_t    a,
  input  logic                      in_n,
  input  logic                      out_n,
  input  logic                      ioreq_n,
  input  trs_bus_pkg::bus_data_t    d_in,
  output trs_bus_pkg::bus_data_t    d_out,
  output logic                      d_oe,
  output trs_bus_pkg::esp_request_t esp_s,
  output logic                      esp_req,
  input  logic                      esp_done,
  output logic                      wait_out,
  output logic                      int_out,
  output logic                      extiosel,
  input  logic [3:0]                conf,
  output logic                      led_red,
  output logic                      led_green,
  output logic                      led_blue,
  output logic [2:0]                led
);

  esp_link_pkg::link_byte_t byte_in, byte_out, param0;
  esp_link_pkg::link_cmd_t  cmd;
  trs_bus_pkg::bus_data_t   dbus_data;
  logic                     byte_valid, action, data_ready_set, esp_ready, esp_sel;

  spi_byte_receiver spi_byte_receiver_i (
    .clk(clk), .rst_n(rst_n), .sck(sck), .mosi(mosi), .cs(cs),
    .byte_out(byte_out), .miso(miso), .byte_in(byte_in), .byte_valid(byte_valid)
  );

  // param1/param2 unused by the kept commands
  command_parser command_parser_i (
    .clk(clk), .rst_n(rst_n), .byte_in(byte_in), .byte_valid(byte_valid),
    .action(action), .cmd(cmd), .param0(param0), .param1(), .param2(),
    .data_ready_set(data_ready_set)
  );

  command_executor command_executor_i (
    .clk(clk), .rst_n(rst_n), .action(action), .cmd(cmd), .param0(param0),
    .d_in(d_in), .a(a), .conf(conf), .byte_out(byte_out), .dbus_data(dbus_data),
    .led_red(led_red), .led_green(led_green), .led_blue(led_blue), .esp_ready(esp_ready)
  );

  bus_port_decoder bus_port_decoder_i (
    .clk(clk), .rst_n(rst_n), .a(a), .in_n(in_n), .out_n(out_n), .ioreq_n(ioreq_n),
    .dbus_data(dbus_data), .data_ready_set(data_ready_set), .esp_done(esp_done),
    .d_out(d_out), .d_oe(d_oe), .esp_s(esp_s), .esp_req(esp_req), .wait_out(wait_out),
    .int_out(int_out), .extiosel(extiosel), .esp_sel(esp_sel)
  );

  assign led = {esp_ready, esp_sel, wait_out};   // status leds

endmodule

// ==== source/bus_port_decoder.sv ====
`timescale 1ns/1ns
`include "trs_io_defines.svh"

module bus_port_decoder (
  input  logic                      clk,
  input  logic                      rst_n,
  input  trs_bus_pkg::bus_addr_t    a,
  input  logic                      in_n,
  input  logic                      out_n,
  input  logic                      ioreq_n,
  input  trs_bus_pkg::bus_data_t    dbus_data,
  input  logic                      data_ready_set,
  input  logic                      esp_done,
  output trs_bus_pkg::bus_data_t    d_out,
  output logic                      d_oe,
  output trs_bus_pkg::esp_request_t esp_s,
  output logic                      esp_req,
  output logic                      wait_out,
  output logic                      int_out,
  output logic                      extiosel,
  output logic                      esp_sel
);

  localparam int REQ_W = $clog2(`ESP_REQ_CYCLES + 1);

  logic                    cpu_rd, cpu_wr;
  logic                    trs_io_hit, frehd_hit, printer_hit;
  logic                    esp_sel_in, esp_sel_out, trs_io_sel;
  logic [`SYNC_STAGES-1:0] access_sync, done_sync;
  logic                    access_prev, done_prev;
  logic                    io_access, done_rise;
  logic [REQ_W-1:0]        req_cnt;

  assign cpu_rd = ~ioreq_n & ~in_n;
  assign cpu_wr = ~ioreq_n & ~out_n;

  assign trs_io_hit  = (a == `TRS_IO_PORT);
  assign frehd_hit   = (a[7:4] == `FREHD_PORT_HI);
  assign printer_hit = (a[7:2] == `PRINTER_PORT_HI);

  assign esp_sel_in  = cpu_rd & (trs_io_hit | frehd_hit | printer_hit);
  assign esp_sel_out = cpu_wr & (trs_io_hit | frehd_hit | printer_hit);
  assign esp_sel     = esp_sel_in | esp_sel_out;
  assign trs_io_sel  = trs_io_hit & (cpu_rd | cpu_wr);

  always_comb begin
    if (cpu_rd && trs_io_hit)       esp_s = trs_bus_pkg::trs_io_in;
    else if (cpu_wr && trs_io_hit)  esp_s = trs_bus_pkg::trs_io_out;
    else if (cpu_rd && frehd_hit)   esp_s = trs_bus_pkg::frehd_in;
    else if (cpu_wr && frehd_hit)   esp_s = trs_bus_pkg::frehd_out;
    else if (cpu_rd && printer_hit) esp_s = trs_bus_pkg::printer_rd;
    else if (cpu_wr && printer_hit) esp_s = trs_bus_pkg::printer_wr;
    else                            esp_s = trs_bus_pkg::no_request;
  end

  // strobes are async to clk
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      access_sync <= '0;
      done_sync   <= '0;
      access_prev <= 1'b0;
      done_prev   <= 1'b0;
    end else begin
      access_sync <= {access_sync[`SYNC_STAGES-2:0], cpu_rd | cpu_wr};
      done_sync   <= {done_sync[`SYNC_STAGES-2:0], esp_done};
      access_prev <= access_sync[`SYNC_STAGES-1];
      done_prev   <= done_sync[`SYNC_STAGES-1];
    end
  end

  assign io_access = access_sync[`SYNC_STAGES-1] & ~access_prev;
  assign done_rise = done_sync[`SYNC_STAGES-1] & ~done_prev;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wait_out <= 1'b0;
      req_cnt  <= '0;
      int_out  <= 1'b0;
    end else begin
      if (io_access && esp_sel) begin
        wait_out <= 1'b1;   // hold the cpu until the ESP is done
        req_cnt  <= REQ_W'(`ESP_REQ_CYCLES);
      end else begin
        if (done_rise)
          wait_out <= 1'b0;
        if (req_cnt != '0)
          req_cnt <= req_cnt - 1'b1;
      end
      if (data_ready_set)
        int_out <= 1'b1;
      else if (io_access && trs_io_sel)
        int_out <= 1'b0;   // any trs-io access acknowledges
    end
  end

  assign esp_req  = (req_cnt != '0);
  assign extiosel = esp_sel_in;
  assign d_oe     = esp_sel_in;
  assign d_out    = esp_sel_in ? dbus_data : '0;

endmodule

// ==== source/command_executor.sv ====
`timescale 1ns/1ns
`include "trs_io_defines.svh"

module command_executor (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     action,
  input  esp_link_pkg::link_cmd_t  cmd,
  input  esp_link_pkg::link_byte_t param0,
  input  trs_bus_pkg::bus_data_t   d_in,
  input  trs_bus_pkg::bus_addr_t   a,
  input  logic [3:0]               conf,
  output esp_link_pkg::link_byte_t byte_out,
  output trs_bus_pkg::bus_data_t   dbus_data,
  output logic                     led_red,
  output logic                     led_green,
  output logic                     led_blue,
  output logic                     esp_ready
);

  esp_link_pkg::link_byte_t esp_status;

  // byte left for the z80 to read
  always_ff @(posedge clk) begin
    if (action && cmd == esp_link_pkg::dbus_write)
      dbus_data <= param0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led_red    <= 1'b0;
      led_green  <= 1'b0;
      led_blue   <= 1'b0;
      esp_status <= '0;
      byte_out   <= '0;
    end else if (action) begin
      case (cmd)
        esp_link_pkg::set_led: begin
          led_red   <= param0[0];
          led_green <= param0[1];
          led_blue  <= param0[2];
        end
        esp_link_pkg::set_esp_status: esp_status <= param0;
        esp_link_pkg::get_cookie:     byte_out <= `TRS_IO_COOKIE;
        esp_link_pkg::get_version:
          byte_out <= {`TRS_IO_VERSION_MAJOR, `TRS_IO_VERSION_MINOR};
        esp_link_pkg::dbus_read:      byte_out <= d_in;   // bus as seen right now
        esp_link_pkg::abus_read:      byte_out <= a;
        esp_link_pkg::get_config:     byte_out <= {4'b0000, ~conf};   // dip switches are active low
        default: ;
      endcase
    end
  end

  assign esp_ready = esp_status[0];

endmodule

// ==== source/command_parser.sv ====
`timescale 1ns/1ns

module command_parser (
  input  logic                     clk,
  input  logic                     rst_n,
  input  esp_link_pkg::link_byte_t byte_in,
  input  logic                     byte_valid,
  output logic                     action,
  output esp_link_pkg::link_cmd_t  cmd,
  output esp_link_pkg::link_byte_t param0,
  output esp_link_pkg::link_byte_t param1,
  output esp_link_pkg::link_byte_t param2,
  output logic                     data_ready_set
);

  esp_link_pkg::parser_state_t state;
  esp_link_pkg::param_count_t  remaining;
  esp_link_pkg::link_cmd_t     cmd_code;
  logic [1:0]                  param_idx;

  assign cmd_code = esp_link_pkg::link_cmd_t'(byte_in);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state          <= esp_link_pkg::idle;
      remaining      <= '0;
      param_idx      <= '0;
      action         <= 1'b0;
      data_ready_set <= 1'b0;
    end else begin
      action         <= 1'b0;
      data_ready_set <= 1'b0;
      if (byte_valid) begin
        case (state)
          esp_link_pkg::idle: begin
            param_idx <= '0;
            case (cmd_code)
              esp_link_pkg::get_cookie, esp_link_pkg::get_version,
              esp_link_pkg::dbus_read, esp_link_pkg::abus_read,
              esp_link_pkg::get_config: action <= 1'b1;
              esp_link_pkg::data_ready: data_ready_set <= 1'b1;   // goes to the bus side
              esp_link_pkg::dbus_write, esp_link_pkg::set_led,
              esp_link_pkg::set_esp_status: begin
                remaining <= 3'd1;
                state     <= esp_link_pkg::read_bytes;
              end
              default: state <= esp_link_pkg::idle;   // unknown code, drop it
            endcase
          end
          esp_link_pkg::read_bytes: begin
            param_idx <= param_idx + 2'd1;
            if (remaining == 3'd1) begin
              action <= 1'b1;
              state  <= esp_link_pkg::idle;
            end else begin
              remaining <= remaining - 3'd1;
            end
          end
          default: state <= esp_link_pkg::idle;
        endcase
      end
    end
  end

  // command and parameters hold until the next command byte
  always_ff @(posedge clk) begin
    if (byte_valid && state == esp_link_pkg::idle)
      cmd <= cmd_code;
    if (byte_valid && state == esp_link_pkg::read_bytes) begin
      case (param_idx)
        2'd0:    param0 <= byte_in;
        2'd1:    param1 <= byte_in;
        default: param2 <= byte_in;
      endcase
    end
  end

endmodule

// ==== source/spi_byte_receiver.sv ====
`timescale 1ns/1ns
`include "trs_io_defines.svh"

module spi_byte_receiver (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     sck,
  input  logic                     mosi,
  input  logic                     cs,
  input  esp_link_pkg::link_byte_t byte_out,
  output logic                     miso,
  output esp_link_pkg::link_byte_t byte_in,
  output logic                     byte_valid
);

  logic [`SYNC_STAGES-1:0]  sck_sync, mosi_sync, cs_sync;
  logic                     sck_prev;
  logic                     sck_rise, sck_fall, cs_active, mosi_bit;
  logic [2:0]               bit_cnt;
  esp_link_pkg::link_byte_t rx_shift, tx_shift;

  assign sck_rise  = sck_sync[`SYNC_STAGES-1] & ~sck_prev;
  assign sck_fall  = ~sck_sync[`SYNC_STAGES-1] & sck_prev;
  assign cs_active = ~cs_sync[`SYNC_STAGES-1];
  assign mosi_bit  = mosi_sync[`SYNC_STAGES-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sck_sync  <= '0;
      mosi_sync <= '0;
      cs_sync   <= '1;   // deselected
      sck_prev  <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[`SYNC_STAGES-2:0], sck};
      mosi_sync <= {mosi_sync[`SYNC_STAGES-2:0], mosi};
      cs_sync   <= {cs_sync[`SYNC_STAGES-2:0], cs};
      sck_prev  <= sck_sync[`SYNC_STAGES-1];
    end
  end

  // msb first
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      rx_shift <= {rx_shift[6:0], mosi_bit};
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
      tx_shift   <= '0;
    end else begin
      byte_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;
      end else begin
        if (sck_rise) begin
          bit_cnt    <= bit_cnt + 3'd1;
          byte_valid <= (bit_cnt == 3'd7);   // eighth bit in
        end
        if (sck_fall) begin
          if (bit_cnt == 3'd1)
            tx_shift <= byte_out;   // first falling edge of the byte
          else
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
      end
    end
  end

  assign byte_in = rx_shift;
  assign miso    = cs_active & tx_shift[7];

endmodule

// ==== source/esp_link_pkg.sv ====
package esp_link_pkg;

  // one byte on the SPI link
  typedef logic [7:0] link_byte_t;

  // command codes sent by the ESP as the first byte of a message
  typedef enum logic [7:0] {
    get_cookie     = 8'd0,
    dbus_read      = 8'd3,
    dbus_write     = 8'd4,
    data_ready     = 8'd5,
    get_version    = 8'd15,
    abus_read      = 8'd18,
    set_led        = 8'd26,
    get_config     = 8'd27,
    set_esp_status = 8'd32
  } link_cmd_t;

  // parameter bytes still expected after the command byte
  typedef logic [2:0] param_count_t;

  typedef enum logic {
    idle,
    read_bytes
  } parser_state_t;

endpackage

// ==== source/trs_bus_pkg.sv ====
package trs_bus_pkg;

  // low byte of the z80 address bus, all that port i/o needs
  typedef logic [7:0] bus_addr_t;

  typedef logic [7:0] bus_data_t;

  // request code shown to the ESP on esp_s
  typedef enum logic [3:0] {
    trs_io_in  = 4'd0,
    trs_io_out = 4'd1,
    frehd_in   = 4'd2,
    frehd_out  = 4'd3,
    printer_rd = 4'd4,
    printer_wr = 4'd5,
    no_request = 4'hF   // idle value, no port selected
  } esp_request_t;

endpackage

// ==== source/trs_io_defines.svh ====
`ifndef TRS_IO_DEFINES_SVH
`define TRS_IO_DEFINES_SVH

// reply to get_cookie, lets the ESP find the FPGA
`define TRS_IO_COOKIE 8'hAF

// packed as {major, minor} into one response byte
`define TRS_IO_VERSION_MAJOR 3'd0
`define TRS_IO_VERSION_MINOR 5'd3

// z80 port map
`define TRS_IO_PORT 8'h1F
`define FREHD_PORT_HI 4'hC    // C0h-CFh, upper nibble
`define PRINTER_PORT_HI 6'h3E // F8h-FBh, bits 7..2

// esp_req pulse length in clk cycles
`define ESP_REQ_CYCLES 50

// flops per asynchronous input
`define SYNC_STAGES 3

`endif
